//--- hdl/wb_pkg.sv
package wb_pkg;

    // architectural widths
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_IDX_W  = 5;
    localparam int CSR_ADDR_W = 14;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // lane operations
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_MUL  = 4'd7,
        OP_CSRW = 4'd8,
        OP_NOP  = 4'd9
    } lane_op_e;

    // one instruction of an issue bundle
    typedef struct packed {
        lane_op_e  op;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        word_t     imm;
        csr_addr_t csr_addr;
        logic      use_imm;
    } issue_slot_t;

    // execute to writeback, one per lane
    typedef struct packed {
        logic      valid;
        logic      gr_we;
        reg_idx_t  dest;
        word_t     result;
        logic      csr_we;
        csr_addr_t csr_addr;
        word_t     csr_wdata;
        word_t     pc;
    } lane_res_t;

    // bypass entry from writeback back into the lanes
    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } fwd_t;

endpackage

//--- hdl/exec_lane.sv
module exec_lane #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                accept,
    input  wb_pkg::issue_slot_t slot,
    input  wb_pkg::word_t       pc,
    input  wb_pkg::word_t       rj_data,
    input  wb_pkg::word_t       rk_data,
    input  wb_pkg::fwd_t        fwd0,
    input  wb_pkg::fwd_t        fwd1,
    input  logic                other_busy,
    output wb_pkg::reg_idx_t    rj_idx,
    output wb_pkg::reg_idx_t    rk_idx,
    output logic                nblock,
    output wb_pkg::lane_res_t   res
);
    import wb_pkg::*;

    localparam int CNT_W = $clog2(MUL_CYCLES) + 1;

    // execute stage
    logic             ex_vld;
    issue_slot_t      ex_slot;
    word_t            ex_pc;
    logic [CNT_W-1:0] mul_cnt;
    logic             retire;

    word_t op_a;
    word_t op_b;
    word_t alu_out;

    // result register towards writeback
    lane_res_t res_d;
    lane_res_t res_q;
    logic      res_vld;
    logic      res_wait;

    // lane 1 is the younger write, so its bypass is checked first
    function automatic word_t pick_operand(reg_idx_t idx, word_t rf_data, fwd_t f0, fwd_t f1);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (f1.we && f1.dest == idx) begin
            val = f1.data;
        end else if (f0.we && f0.dest == idx) begin
            val = f0.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rj_idx = ex_slot.rj;
    assign rk_idx = ex_slot.rk;

    assign op_a = pick_operand(ex_slot.rj, rj_data, fwd0, fwd1);
    assign op_b = ex_slot.use_imm ? ex_slot.imm : pick_operand(ex_slot.rk, rk_data, fwd0, fwd1);

    always_comb begin
        case (ex_slot.op)
            OP_ADD:  alu_out = op_a + op_b;
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_SLL:  alu_out = op_a << op_b[4:0];
            OP_SRL:  alu_out = op_a >> op_b[4:0];
            // multicycle path sampled when the count runs out
            OP_MUL:  alu_out = op_a * op_b;
            default: alu_out = op_a;
        endcase
    end

    always_comb begin
        res_d.valid     = 1'b1;
        res_d.gr_we     = !(ex_slot.op inside {OP_CSRW, OP_NOP});
        res_d.dest      = ex_slot.rd;
        res_d.result    = alu_out;
        res_d.csr_we    = (ex_slot.op == OP_CSRW);
        res_d.csr_addr  = ex_slot.csr_addr;
        res_d.csr_wdata = op_a;
        res_d.pc        = ex_pc;
    end

    assign retire = ex_vld && (mul_cnt == '0);

    // stall the bundle while a multiply sits in this lane
    assign nblock = !(ex_vld && ex_slot.op == OP_MUL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_vld  <= 1'b0;
            mul_cnt <= '0;
        end else if (accept) begin
            ex_vld  <= 1'b1;
            mul_cnt <= (slot.op == OP_MUL) ? CNT_W'(MUL_CYCLES - 1) : '0;
        end else if (retire) begin
            ex_vld <= 1'b0;
        end else if (ex_vld) begin
            mul_cnt <= mul_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_slot <= slot;
            ex_pc   <= pc;
        end
    end

    // a result finished while the partner lane multiplies waits for it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_vld  <= 1'b0;
            res_wait <= 1'b0;
        end else if (retire) begin
            res_vld  <= 1'b1;
            res_wait <= other_busy;
        end else if (!(res_wait && other_busy)) begin
            res_vld  <= 1'b0;
            res_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            res_q <= res_d;
        end
    end

    always_comb begin
        res       = res_q;
        res.valid = res_vld && !(res_wait && other_busy);
    end

endmodule

//--- hdl/wb_stage.sv
module wb_stage (
    input  wb_pkg::lane_res_t res0,
    input  wb_pkg::lane_res_t res1,
    // register file write ports
    output logic              rf_we0,
    output logic              rf_we1,
    output wb_pkg::reg_idx_t  rf_waddr0,
    output wb_pkg::reg_idx_t  rf_waddr1,
    output wb_pkg::word_t     rf_wdata0,
    output wb_pkg::word_t     rf_wdata1,
    // single csr write port
    output logic              csr_we,
    output wb_pkg::csr_addr_t csr_addr,
    output wb_pkg::word_t     csr_wdata,
    // bypass back into both lanes
    output wb_pkg::fwd_t      fwd0,
    output wb_pkg::fwd_t      fwd1
);

    logic lane0_wr;
    logic lane1_wr;
    logic same_dest;

    assign lane0_wr  = res0.valid && res0.gr_we;
    assign lane1_wr  = res1.valid && res1.gr_we;
    assign same_dest = (res0.dest == res1.dest) && (res0.dest != '0);

    // later slot wins on a shared destination
    assign rf_we1    = lane1_wr;
    assign rf_waddr1 = res1.dest;
    assign rf_wdata1 = res1.result;

    assign rf_we0    = lane0_wr && !(lane1_wr && same_dest);
    assign rf_waddr0 = res0.dest;
    assign rf_wdata0 = res0.result;

    // lane 0 has priority on the csr port
    always_comb begin
        if (res0.valid && res0.csr_we) begin
            csr_we    = 1'b1;
            csr_addr  = res0.csr_addr;
            csr_wdata = res0.csr_wdata;
        end else if (res1.valid && res1.csr_we && res0.valid) begin
            // lane 1 only together with a live lane 0
            csr_we    = 1'b1;
            csr_addr  = res1.csr_addr;
            csr_wdata = res1.csr_wdata;
        end else begin
            csr_we    = 1'b0;
            csr_addr  = '0;
            csr_wdata = '0;
        end
    end

    // forward only what actually reaches the register file
    always_comb begin
        fwd0.we   = rf_we0;
        fwd0.dest = rf_waddr0;
        fwd0.data = rf_wdata0;
    end

    always_comb begin
        fwd1.we   = rf_we1;
        fwd1.dest = rf_waddr1;
        fwd1.data = rf_wdata1;
    end

endmodule

//--- hdl/gpr_file.sv
module gpr_file (
    input  logic             clk,
    input  logic             arst_n,
    // lane operand reads
    input  wb_pkg::reg_idx_t raddr0,
    input  wb_pkg::reg_idx_t raddr1,
    input  wb_pkg::reg_idx_t raddr2,
    input  wb_pkg::reg_idx_t raddr3,
    output wb_pkg::word_t    rdata0,
    output wb_pkg::word_t    rdata1,
    output wb_pkg::word_t    rdata2,
    output wb_pkg::word_t    rdata3,
    // writeback
    input  logic             we0,
    input  logic             we1,
    input  wb_pkg::reg_idx_t waddr0,
    input  wb_pkg::reg_idx_t waddr1,
    input  wb_pkg::word_t    wdata0,
    input  wb_pkg::word_t    wdata1,
    // debug read
    input  wb_pkg::reg_idx_t dbg_idx,
    output wb_pkg::word_t    dbg_data
);
    import wb_pkg::*;

    word_t regs [NUM_REGS];

    // register 0 is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0 && waddr0 != '0) begin
                regs[waddr0] <= wdata0;
            end
            // port 1 last, so it wins on the same address
            if (we1 && waddr1 != '0) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    assign rdata0   = regs[raddr0];
    assign rdata1   = regs[raddr1];
    assign rdata2   = regs[raddr2];
    assign rdata3   = regs[raddr3];
    assign dbg_data = regs[dbg_idx];

endmodule

//--- hdl/csr_file.sv
module csr_file #(
    parameter int CSR_DEPTH = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              we,
    input  wb_pkg::csr_addr_t addr,
    input  wb_pkg::word_t     wdata,
    input  wb_pkg::csr_addr_t dbg_addr,
    output wb_pkg::word_t     dbg_data
);
    import wb_pkg::*;

    localparam int IDX_W = (CSR_DEPTH > 1) ? $clog2(CSR_DEPTH) : 1;

    word_t      csr_q [CSR_DEPTH];
    logic       wr_hit;
    logic       dbg_hit;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] dbg_idx;

    // only the low address bits select a csr
    assign wr_hit  = (addr < CSR_DEPTH);
    assign dbg_hit = (dbg_addr < CSR_DEPTH);
    assign wr_idx  = addr[IDX_W-1:0];
    assign dbg_idx = dbg_addr[IDX_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < CSR_DEPTH; i++) begin
                csr_q[i] <= '0;
            end
        end else if (we && wr_hit) begin
            csr_q[wr_idx] <= wdata;
        end
    end

    // unimplemented addresses read as zero
    assign dbg_data = dbg_hit ? csr_q[dbg_idx] : '0;

endmodule

//--- hdl/dual_wb_top.sv
module dual_wb_top #(
    parameter int CSR_DEPTH  = 16,
    parameter int MUL_CYCLES = 3
) (
    input  logic                clk,
    input  logic                arst_n,
    // issue bundle
    input  logic                bundle_valid,
    output logic                bundle_ready,
    input  wb_pkg::issue_slot_t slot0,
    input  wb_pkg::issue_slot_t slot1,
    input  wb_pkg::word_t       pc,
    // debug reads
    input  wb_pkg::reg_idx_t    dbg_gpr_idx,
    output wb_pkg::word_t       dbg_gpr_data,
    input  wb_pkg::csr_addr_t   dbg_csr_addr,
    output wb_pkg::word_t       dbg_csr_data
);
    import wb_pkg::*;

    logic      accept;
    logic      nblock0;
    logic      nblock1;
    word_t     pc1;

    reg_idx_t  rj_idx0;
    reg_idx_t  rk_idx0;
    reg_idx_t  rj_idx1;
    reg_idx_t  rk_idx1;
    word_t     rj_data0;
    word_t     rk_data0;
    word_t     rj_data1;
    word_t     rk_data1;

    lane_res_t res0;
    lane_res_t res1;
    fwd_t      fwd0;
    fwd_t      fwd1;

    logic      rf_we0;
    logic      rf_we1;
    reg_idx_t  rf_waddr0;
    reg_idx_t  rf_waddr1;
    word_t     rf_wdata0;
    word_t     rf_wdata1;

    logic      csr_we;
    csr_addr_t csr_addr;
    word_t     csr_wdata;

    // whole bundle stalls when either lane blocks
    assign bundle_ready = nblock0 && nblock1;
    assign accept       = bundle_valid && bundle_ready;
    assign pc1          = pc + 32'd4;

    exec_lane #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_lane0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .accept     (accept),
        .slot       (slot0),
        .pc         (pc),
        .rj_data    (rj_data0),
        .rk_data    (rk_data0),
        .fwd0       (fwd0),
        .fwd1       (fwd1),
        .other_busy (!nblock1),
        .rj_idx     (rj_idx0),
        .rk_idx     (rk_idx0),
        .nblock     (nblock0),
        .res        (res0)
    );

    exec_lane #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_lane1 (
        .clk        (clk),
        .arst_n     (arst_n),
        .accept     (accept),
        .slot       (slot1),
        .pc         (pc1),
        .rj_data    (rj_data1),
        .rk_data    (rk_data1),
        .fwd0       (fwd0),
        .fwd1       (fwd1),
        .other_busy (!nblock0),
        .rj_idx     (rj_idx1),
        .rk_idx     (rk_idx1),
        .nblock     (nblock1),
        .res        (res1)
    );

    wb_stage u_wb (
        .res0      (res0),
        .res1      (res1),
        .rf_we0    (rf_we0),
        .rf_we1    (rf_we1),
        .rf_waddr0 (rf_waddr0),
        .rf_waddr1 (rf_waddr1),
        .rf_wdata0 (rf_wdata0),
        .rf_wdata1 (rf_wdata1),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .fwd0      (fwd0),
        .fwd1      (fwd1)
    );

    gpr_file u_gpr (
        .clk      (clk),
        .arst_n   (arst_n),
        .raddr0   (rj_idx0),
        .raddr1   (rk_idx0),
        .raddr2   (rj_idx1),
        .raddr3   (rk_idx1),
        .rdata0   (rj_data0),
        .rdata1   (rk_data0),
        .rdata2   (rj_data1),
        .rdata3   (rk_data1),
        .we0      (rf_we0),
        .we1      (rf_we1),
        .waddr0   (rf_waddr0),
        .waddr1   (rf_waddr1),
        .wdata0   (rf_wdata0),
        .wdata1   (rf_wdata1),
        .dbg_idx  (dbg_gpr_idx),
        .dbg_data (dbg_gpr_data)
    );

    csr_file #(
        .CSR_DEPTH (CSR_DEPTH)
    ) u_csr (
        .clk      (clk),
        .arst_n   (arst_n),
        .we       (csr_we),
        .addr     (csr_addr),
        .wdata    (csr_wdata),
        .dbg_addr (dbg_csr_addr),
        .dbg_data (dbg_csr_data)
    );

endmodule

//--- sim/tb_dual_wb.sv
module tb_dual_wb;
    timeunit 1ns;
    timeprecision 1ps;
    import wb_pkg::*;

    localparam int CSR_DEPTH  = 16;
    localparam int MUL_CYCLES = 3;
    localparam int WAIT_LIMIT = 40;

    // one table row with a bundle, a back to back flag and the read back masks
    typedef struct packed {
        issue_slot_t s0;
        issue_slot_t s1;
        logic        chain;
        logic [31:0] gpr_chk;
        logic [31:0] csr_chk;
    } entry_t;

    logic        clk;
    logic        arst_n;
    logic        bundle_valid;
    logic        bundle_ready;
    issue_slot_t slot0;
    issue_slot_t slot1;
    word_t       pc;
    reg_idx_t    dbg_gpr_idx;
    word_t       dbg_gpr_data;
    csr_addr_t   dbg_csr_addr;
    word_t       dbg_csr_data;

    entry_t bundles_q[$];
    word_t  ref_gpr [32];
    word_t  ref_csr [CSR_DEPTH];
    word_t  lcg_state;

    dual_wb_top #(
        .CSR_DEPTH  (CSR_DEPTH),
        .MUL_CYCLES (MUL_CYCLES)
    ) uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .bundle_valid (bundle_valid),
        .bundle_ready (bundle_ready),
        .slot0        (slot0),
        .slot1        (slot1),
        .pc           (pc),
        .dbg_gpr_idx  (dbg_gpr_idx),
        .dbg_gpr_data (dbg_gpr_data),
        .dbg_csr_addr (dbg_csr_addr),
        .dbg_csr_data (dbg_csr_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic issue_slot_t make_slot(lane_op_e op, int rd, int rj, int rk,
                                              word_t imm, logic use_imm, int csr);
        issue_slot_t s;
        s.op       = op;
        s.rd       = reg_idx_t'(rd);
        s.rj       = reg_idx_t'(rj);
        s.rk       = reg_idx_t'(rk);
        s.imm      = imm;
        s.use_imm  = use_imm;
        s.csr_addr = csr_addr_t'(csr);
        return s;
    endfunction

    function automatic issue_slot_t reg_op(lane_op_e op, int rd, int rj, int rk);
        return make_slot(op, rd, rj, rk, '0, 1'b0, 0);
    endfunction

    function automatic issue_slot_t imm_op(lane_op_e op, int rd, int rj, word_t imm);
        return make_slot(op, rd, rj, 0, imm, 1'b1, 0);
    endfunction

    function automatic issue_slot_t csr_write(int csr, int rj);
        return make_slot(OP_CSRW, 0, rj, 0, '0, 1'b0, csr);
    endfunction

    function automatic word_t alu_ref(lane_op_e op, word_t a, word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_MUL:  return a * b;
            default: return a;
        endcase
    endfunction

    function automatic word_t operand(reg_idx_t idx);
        return (idx == '0) ? '0 : ref_gpr[idx];
    endfunction

    // both lanes read the state from before the bundle
    function automatic void apply_reference(entry_t e);
        word_t a0;
        word_t b0;
        word_t a1;
        word_t b1;
        a0 = operand(e.s0.rj);
        b0 = e.s0.use_imm ? e.s0.imm : operand(e.s0.rk);
        a1 = operand(e.s1.rj);
        b1 = e.s1.use_imm ? e.s1.imm : operand(e.s1.rk);
        // lane 1 written last, so it owns a shared destination
        if (!(e.s0.op inside {OP_CSRW, OP_NOP}) && e.s0.rd != '0) begin
            ref_gpr[e.s0.rd] = alu_ref(e.s0.op, a0, b0);
        end
        if (!(e.s1.op inside {OP_CSRW, OP_NOP}) && e.s1.rd != '0) begin
            ref_gpr[e.s1.rd] = alu_ref(e.s1.op, a1, b1);
        end
        if (e.s0.op == OP_CSRW) begin
            if (e.s0.csr_addr < CSR_DEPTH) begin
                ref_csr[e.s0.csr_addr] = a0;
            end
        end else if (e.s1.op == OP_CSRW && e.s1.csr_addr < CSR_DEPTH) begin
            ref_csr[e.s1.csr_addr] = a1;
        end
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_entry(input issue_slot_t s0, input issue_slot_t s1, input logic chain,
                             input logic [31:0] gpr_chk, input logic [31:0] csr_chk);
        entry_t e;
        e.s0      = s0;
        e.s1      = s1;
        e.chain   = chain;
        e.gpr_chk = gpr_chk;
        e.csr_chk = csr_chk;
        bundles_q.push_back(e);
    endtask

    task automatic build_table();
        // load r1..r8 with random values
        for (int i = 1; i <= 7; i += 2) begin
            add_entry(imm_op(OP_ADD, i, 0, next_random()), imm_op(OP_ADD, i + 1, 0, next_random()),
                      i != 7, 32'h0000_01fe, '0);
        end
        // alu ops with a write to r0
        add_entry(reg_op(OP_SUB, 9, 1, 2), reg_op(OP_XOR, 10, 3, 4), 1'b1, '0, '0);
        add_entry(imm_op(OP_AND, 11, 5, next_random()), reg_op(OP_OR, 12, 6, 7), 1'b1, '0, '0);
        add_entry(imm_op(OP_SLL, 13, 8, 32'd5), reg_op(OP_SRL, 14, 1, 2), 1'b1, '0, '0);
        add_entry(reg_op(OP_ADD, 0, 1, 2), reg_op(OP_OR, 15, 0, 3), 1'b0, 32'h0000_fe01, '0);
        // shared destination
        add_entry(reg_op(OP_ADD, 16, 1, 2), reg_op(OP_SUB, 16, 3, 4), 1'b0, 32'h0001_0000, '0);
        // back to back dependencies through the bypass
        add_entry(imm_op(OP_ADD, 17, 1, next_random()), reg_op(OP_XOR, 18, 2, 3), 1'b1, '0, '0);
        add_entry(reg_op(OP_ADD, 19, 17, 18), reg_op(OP_SUB, 20, 18, 17), 1'b1, '0, '0);
        add_entry(imm_op(OP_OR, 21, 19, next_random()), reg_op(OP_ADD, 22, 20, 16), 1'b1, '0, '0);
        add_entry(imm_op(OP_ADD, 23, 1, next_random()), imm_op(OP_ADD, 23, 2, next_random()),
                  1'b1, '0, '0);
        add_entry(reg_op(OP_ADD, 24, 23, 22), reg_op(OP_SUB, 25, 21, 23), 1'b0,
                  32'h03fe_0000, '0);
        // csr port priority and out of range addresses
        add_entry(csr_write(1, 1), csr_write(2, 2), 1'b1, '0, '0);
        add_entry(imm_op(OP_ADD, 26, 3, next_random()), csr_write(2, 3), 1'b1, '0, '0);
        add_entry(csr_write(20, 4), reg_op(OP_NOP, 0, 0, 0), 1'b1, '0, '0);
        add_entry(csr_write(14'h1003, 5), csr_write(4, 6), 1'b1, '0, '0);
        add_entry(csr_write(5, 26), reg_op(OP_NOP, 0, 0, 0), 1'b0, 32'h0400_0000, 32'h0010_803e);
        // multiply in lane 0, lane 1, then both
        add_entry(reg_op(OP_MUL, 27, 1, 2), imm_op(OP_ADD, 28, 3, next_random()), 1'b1, '0, '0);
        add_entry(reg_op(OP_ADD, 29, 27, 28), imm_op(OP_MUL, 30, 28, next_random()), 1'b1, '0, '0);
        add_entry(reg_op(OP_MUL, 31, 29, 30), reg_op(OP_MUL, 1, 27, 28), 1'b1, '0, '0);
        add_entry(reg_op(OP_ADD, 2, 31, 1), csr_write(7, 31), 1'b0, 32'hf800_0006, 32'h0000_0080);
        // final sweep of everything
        add_entry(reg_op(OP_NOP, 0, 0, 0), reg_op(OP_NOP, 0, 0, 0), 1'b0, '1, '1);
    endtask

    // debug port reads starting and ending on a rising edge
    task automatic check_state(input logic [31:0] gpr_chk, input logic [31:0] csr_chk);
        word_t exp;
        for (int i = 0; i < 32; i++) begin
            if (gpr_chk[i]) begin
                dbg_gpr_idx <= reg_idx_t'(i);
                @(negedge clk);
                check_value($sformatf("r%0d", i), dbg_gpr_data, ref_gpr[i]);
                @(posedge clk);
            end
        end
        for (int i = 0; i < 32; i++) begin
            if (csr_chk[i]) begin
                exp = (i < CSR_DEPTH) ? ref_csr[i] : '0;
                dbg_csr_addr <= csr_addr_t'(i);
                @(negedge clk);
                check_value($sformatf("csr %0d", i), dbg_csr_data, exp);
                @(posedge clk);
            end
        end
    endtask

    task automatic issue_bundle(input entry_t e, input int n);
        int waited;
        slot0        <= e.s0;
        slot1        <= e.s1;
        pc           <= pc + 32'd8;
        bundle_valid <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!bundle_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("bundle %0d was never accepted by the DUT", n);
                $display("TB FAILED");
                $fatal(1, "handshake timeout");
            end
            @(negedge clk);
        end
        @(posedge clk);
        apply_reference(e);
        if (!e.chain) begin
            bundle_valid <= 1'b0;
        end
        if (e.s0.op == OP_MUL || e.s1.op == OP_MUL) begin
            @(negedge clk);
            check_value("bundle_ready during multiply", word_t'(bundle_ready), '0);
            @(posedge clk);
        end
    endtask

    // wait for ready, then two edges for the last writes to land
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!bundle_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("DUT stayed stalled after the last bundle");
                $display("TB FAILED");
                $fatal(1, "stall timeout");
            end
            @(negedge clk);
        end
        @(posedge clk);
        @(posedge clk);
    endtask

    initial begin
        arst_n       = 1'b0;
        bundle_valid = 1'b0;
        slot0        = '0;
        slot1        = '0;
        pc           = 32'h0000_1000;
        dbg_gpr_idx  = '0;
        dbg_csr_addr = '0;
        lcg_state    = 32'd31483;
        for (int i = 0; i < 32; i++) begin
            ref_gpr[i] = '0;
        end
        for (int i = 0; i < CSR_DEPTH; i++) begin
            ref_csr[i] = '0;
        end
        build_table();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("bundle_ready after reset", word_t'(bundle_ready), 32'd1);
        @(posedge clk);
        check_state('1, '1);
        foreach (bundles_q[n]) begin
            issue_bundle(bundles_q[n], n);
            if (!bundles_q[n].chain) begin
                wait_idle();
                check_state(bundles_q[n].gpr_chk, bundles_q[n].csr_chk);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- verilog.f
hdl/wb_pkg.sv
hdl/exec_lane.sv
hdl/wb_stage.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/dual_wb_top.sv
sim/tb_dual_wb.sv

//--- Bender.yml
package:
  name: dual_wb

sources:
  - hdl/wb_pkg.sv
  - hdl/exec_lane.sv
  - hdl/wb_stage.sv
  - hdl/gpr_file.sv
  - hdl/csr_file.sv
  - hdl/dual_wb_top.sv
  - target: simulation
    files:
      - sim/tb_dual_wb.sv
